//--- Makefile
TOP := tb_afifo
SIM := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f --top-module $(TOP)
	out=$$($(SIM)); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- bench/tb_afifo.sv
`timescale 1ns/10ps

module tb_afifo;

    import afifo_pkg::*;

    localparam int    WAIT_LIMIT  = 20;
    localparam int    DRAIN_LIMIT = 200;
    localparam int    STREAM_CYC  = 200;
    localparam int    IDLE_SETTLE = 6;
    localparam data_t DROPPED     = 8'ha5;

    logic  wclk;
    logic  wrstn;
    logic  winc;
    data_t wdata;
    logic  wfull;
    logic  rclk;
    logic  rrstn;
    logic  rinc;
    data_t rdata;
    logic  rempty;

    // words accepted by the FIFO in arrival order
    data_t ref_q[$];
    data_t last_read;
    int    checks;
    int    errors;
    logic  timed_out;

    afifo_top dut (
        .wclk   (wclk),
        .wrstn  (wrstn),
        .winc   (winc),
        .wdata  (wdata),
        .wfull  (wfull),
        .rclk   (rclk),
        .rrstn  (rrstn),
        .rinc   (rinc),
        .rdata  (rdata),
        .rempty (rempty)
    );

    // ========================================
    // clocks
    // ========================================

    initial begin
        wclk = 1'b0;
        forever #14 wclk = ~wclk;
    end

    initial begin
        rclk = 1'b0;
        forever #20 rclk = ~rclk;
    end

    // ========================================
    // helpers
    // ========================================

    task automatic check_bit(input string sig, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string sig, input data_t exp, input data_t act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("TIMEOUT at %0t: %s did not happen in time", $time, what);
        errors++;
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    // drives one write strobe and queues the word if wfull was low
    task automatic write_word(input data_t d, output logic was_full);
        @(posedge wclk);
        #2;
        was_full = wfull;
        winc     = 1'b1;
        wdata    = d;
        if (!was_full) begin
            ref_q.push_back(d);
        end
        @(posedge wclk);
        #2;
        winc = 1'b0;
    endtask

    // drives one read strobe and samples rdata after the edge that takes it
    task automatic read_word(output data_t got, output logic was_empty);
        @(posedge rclk);
        #2;
        was_empty = rempty;
        rinc      = 1'b1;
        @(posedge rclk);
        #2;
        rinc = 1'b0;
        got  = rdata;
    endtask

    task automatic pop_and_compare(input data_t got);
        data_t exp;
        checks++;
        assert (ref_q.size() > 0) else begin
            $display("ERROR at %0t: a read was accepted with nothing expected", $time);
            errors++;
        end
        if (ref_q.size() > 0) begin
            exp       = ref_q.pop_front();
            last_read = exp;
            check_byte("rdata", exp, got);
        end
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        @(posedge rclk);
        #2;
        while (rempty && n < WAIT_LIMIT) begin
            @(posedge rclk);
            #2;
            n++;
        end
        if (rempty) begin
            report_timeout("rempty falling after a write");
        end
    endtask

    // ========================================
    // tests
    // ========================================

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        @(posedge rclk);
        #2;
        check_bit("rempty", 1'b1, rempty);
        @(posedge wclk);
        #2;
        check_bit("wfull", 1'b0, wfull);
        finish_test("reset state", e0);
    endtask

    task automatic test_single_word();
        int    e0;
        logic  was_full;
        logic  was_empty;
        data_t got;
        e0 = errors;
        write_word(8'h5c, was_full);
        check_bit("wfull", 1'b0, was_full);
        wait_not_empty();
        if (!timed_out) begin
            read_word(got, was_empty);
            check_bit("rempty", 1'b0, was_empty);
            check_byte("rdata", 8'h5c, got);
            if (!was_empty) begin
                void'(ref_q.pop_front());
            end
            check_bit("rempty", 1'b1, rempty);
        end
        finish_test("single word", e0);
    endtask

    task automatic test_fill_overflow();
        int    e0;
        logic  was_full;
        logic  was_empty;
        data_t got;
        e0 = errors;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            write_word(data_t'(i + 'h30), was_full);
            check_bit("wfull", 1'b0, was_full);
        end
        check_bit("wfull", 1'b1, wfull);

        // this one must be dropped
        write_word(DROPPED, was_full);
        check_bit("wfull", 1'b1, was_full);

        wait_not_empty();
        if (!timed_out) begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                read_word(got, was_empty);
                check_bit("rempty", 1'b0, was_empty);
                if (!was_empty) begin
                    pop_and_compare(got);
                end
                checks++;
                assert (got !== DROPPED) else begin
                    $display("CHECK FAILED at %0t: rdata expected anything but %h, got %h",
                             $time, DROPPED, got);
                    errors++;
                end
            end
            check_bit("rempty", 1'b1, rempty);
        end
        finish_test("fill and overflow", e0);
    endtask

    task automatic test_read_empty();
        int    e0;
        logic  was_empty;
        data_t got;
        e0 = errors;
        read_word(got, was_empty);
        check_bit("rempty", 1'b1, was_empty);
        check_byte("rdata", last_read, got);
        check_bit("rempty", 1'b1, rempty);
        finish_test("read while empty", e0);
    endtask

    task automatic test_random_stream();
        int    e0;
        int    idle;
        int    n;
        logic  pend;
        logic  was_empty;
        data_t got;
        e0   = errors;
        pend = 1'b0;
        fork
            begin
                repeat (STREAM_CYC) begin
                    @(posedge wclk);
                    #2;
                    winc  = 1'($urandom_range(1, 0));
                    wdata = 8'($urandom);
                    if (winc && !wfull) begin
                        ref_q.push_back(wdata);
                    end
                end
                @(posedge wclk);
                #2;
                winc = 1'b0;
            end
            begin
                repeat (STREAM_CYC) begin
                    @(posedge rclk);
                    #2;
                    if (pend) begin
                        pop_and_compare(rdata);
                    end
                    rinc = 1'($urandom_range(1, 0));
                    pend = rinc && !rempty;
                end
                @(posedge rclk);
                #2;
                if (pend) begin
                    pop_and_compare(rdata);
                end
                rinc = 1'b0;
            end
        join

        // empty is only trusted once it has stayed high past the pointer crossing
        idle = 0;
        n    = 0;
        while (idle < IDLE_SETTLE && n < DRAIN_LIMIT) begin
            @(posedge rclk);
            #2;
            if (rempty) begin
                idle++;
            end else begin
                idle = 0;
                read_word(got, was_empty);
                if (!was_empty) begin
                    pop_and_compare(got);
                end
            end
            n++;
        end
        if (idle < IDLE_SETTLE) begin
            report_timeout("draining the FIFO to empty");
        end
        checks++;
        assert (ref_q.size() == 0) else begin
            $display("CHECK FAILED at %0t: ref_q size expected 0, got %0d",
                     $time, ref_q.size());
            errors++;
        end
        finish_test("random streaming", e0);
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        void'($urandom(43));
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        last_read = '0;
        wrstn     = 1'b0;
        rrstn     = 1'b0;
        winc      = 1'b0;
        wdata     = '0;
        rinc      = 1'b0;

        // each reset is released on its own clock
        fork
            begin
                repeat (3) @(posedge wclk);
                #2;
                wrstn = 1'b1;
            end
            begin
                repeat (3) @(posedge rclk);
                #2;
                rrstn = 1'b1;
            end
        join

        test_reset_state();
        if (!timed_out) begin
            test_single_word();
        end
        if (!timed_out) begin
            test_fill_overflow();
        end
        if (!timed_out) begin
            test_read_empty();
        end
        if (!timed_out) begin
            test_random_stream();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- design/afifo_mem.sv
`timescale 1ns/10ps

module afifo_mem (
    // write port
    input  logic              wclk,
    input  afifo_pkg::mem_wr_t mem_wr,

    // read port
    input  logic              rclk,
    input  logic              rrstn,
    input  afifo_pkg::mem_rd_t mem_rd,
    output afifo_pkg::data_t  rdata
);

    import afifo_pkg::*;

    // ========================================
    // storage
    // ========================================

    data_t mem [FIFO_DEPTH];

    // the write control already gates the enable with wfull
    always_ff @(posedge wclk) begin
        if (mem_wr.en) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // ========================================
    // registered read port
    // ========================================

    // rdata only moves on an accepted read and holds in between
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rdata <= '0;
        end else if (mem_rd.en) begin
            rdata <= mem[mem_rd.addr];
        end
    end

endmodule

//--- design/afifo_pkg.sv
package afifo_pkg;

    // ========================================
    // sizes
    // ========================================

    // depth must be a power of two for the gray pointer scheme to work
    localparam int FIFO_DEPTH = 16;
    localparam int DATA_W     = 8;
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);

    // one extra bit tells a full FIFO apart from an empty one
    localparam int PTR_W      = ADDR_W + 1;

    // ========================================
    // types
    // ========================================

    typedef logic [DATA_W-1:0] data_t;

    // holds either the binary or the gray form of a pointer
    typedef logic [PTR_W-1:0] ptr_t;

    // memory write port, driven from the write domain
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
        data_t             data;
    } mem_wr_t;

    // memory read port, driven from the read domain
    typedef struct packed {
        logic              en;
        logic [ADDR_W-1:0] addr;
    } mem_rd_t;

    // adjacent values differ in one bit, so a pointer can cross safely
    function automatic ptr_t bin2gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

endpackage

//--- design/afifo_rd_ctrl.sv
`timescale 1ns/10ps

module afifo_rd_ctrl (
    input  logic               rclk,
    input  logic               rrstn,

    // read strobe from outside
    input  logic               rinc,

    // pointer crossing
    input  afifo_pkg::ptr_t    wptr_gray,
    output afifo_pkg::ptr_t    rptr_gray,

    // memory read port and status
    output afifo_pkg::mem_rd_t mem_rd,
    output logic               rempty
);

    import afifo_pkg::*;

    ptr_t rbin;
    ptr_t rbin_next;
    ptr_t rgray_next;
    ptr_t rq1_wptr;
    ptr_t rq2_wptr;
    logic rd_acc;
    logic rempty_next;

    // ========================================
    // write pointer synchronizer
    // ========================================

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rq1_wptr <= '0;
            rq2_wptr <= '0;
        end else begin
            rq1_wptr <= wptr_gray;
            rq2_wptr <= rq1_wptr;
        end
    end

    // ========================================
    // read pointer
    // ========================================

    assign rd_acc     = rinc && !rempty;
    assign rbin_next  = rbin + PTR_W'(rd_acc);
    assign rgray_next = bin2gray(rbin_next);

    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rbin      <= '0;
            rptr_gray <= '0;
        end else begin
            rbin      <= rbin_next;
            rptr_gray <= rgray_next;
        end
    end

    // ========================================
    // empty flag
    // ========================================

    // equal pointers including the wrap bit mean nothing is left to read
    assign rempty_next = (rgray_next == rq2_wptr);

    // empty after reset, and it drops only once a write pointer has crossed
    always_ff @(posedge rclk or negedge rrstn) begin
        if (!rrstn) begin
            rempty <= 1'b1;
        end else begin
            rempty <= rempty_next;
        end
    end

    // ========================================
    // memory read port
    // ========================================

    // the address is the current pointer, the memory registers the word
    always_comb begin
        mem_rd.en   = rd_acc;
        mem_rd.addr = rbin[ADDR_W-1:0];
    end

endmodule

//--- design/afifo_top.sv
`timescale 1ns/10ps

module afifo_top (
    // write domain
    input  logic             wclk,
    input  logic             wrstn,
    input  logic             winc,
    input  afifo_pkg::data_t wdata,
    output logic             wfull,

    // read domain
    input  logic             rclk,
    input  logic             rrstn,
    input  logic             rinc,
    output afifo_pkg::data_t rdata,
    output logic             rempty
);

    import afifo_pkg::*;

    // gray pointers crossing between the domains
    ptr_t    wptr_gray;
    ptr_t    rptr_gray;

    // memory ports
    mem_wr_t mem_wr;
    mem_rd_t mem_rd;

    // ========================================
    // write side
    // ========================================

    afifo_wr_ctrl u_wr_ctrl (
        .wclk      (wclk),
        .wrstn     (wrstn),
        .winc      (winc),
        .wdata     (wdata),
        .rptr_gray (rptr_gray),
        .wptr_gray (wptr_gray),
        .mem_wr    (mem_wr),
        .wfull     (wfull)
    );

    // ========================================
    // read side
    // ========================================

    afifo_rd_ctrl u_rd_ctrl (
        .rclk      (rclk),
        .rrstn     (rrstn),
        .rinc      (rinc),
        .wptr_gray (wptr_gray),
        .rptr_gray (rptr_gray),
        .mem_rd    (mem_rd),
        .rempty    (rempty)
    );

    // ========================================
    // storage
    // ========================================

    afifo_mem u_mem (
        .wclk   (wclk),
        .mem_wr (mem_wr),
        .rclk   (rclk),
        .rrstn  (rrstn),
        .mem_rd (mem_rd),
        .rdata  (rdata)
    );

endmodule

//--- design/afifo_wr_ctrl.sv
`timescale 1ns/10ps

module afifo_wr_ctrl (
    input  logic               wclk,
    input  logic               wrstn,

    // write strobe and data from outside
    input  logic               winc,
    input  afifo_pkg::data_t   wdata,

    // pointer crossing
    input  afifo_pkg::ptr_t    rptr_gray,
    output afifo_pkg::ptr_t    wptr_gray,

    // memory write port and status
    output afifo_pkg::mem_wr_t mem_wr,
    output logic               wfull
);

    import afifo_pkg::*;

    ptr_t wbin;
    ptr_t wbin_next;
    ptr_t wgray_next;
    ptr_t wq1_rptr;
    ptr_t wq2_rptr;
    ptr_t rptr_full;
    logic wr_acc;
    logic wfull_next;

    // ========================================
    // read pointer synchronizer
    // ========================================

    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wq1_rptr <= '0;
            wq2_rptr <= '0;
        end else begin
            wq1_rptr <= rptr_gray;
            wq2_rptr <= wq1_rptr;
        end
    end

    // ========================================
    // write pointer
    // ========================================

    assign wr_acc     = winc && !wfull;
    assign wbin_next  = wbin + PTR_W'(wr_acc);
    assign wgray_next = bin2gray(wbin_next);

    // the gray copy is registered so only one bit moves per write
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wbin      <= '0;
            wptr_gray <= '0;
        end else begin
            wbin      <= wbin_next;
            wptr_gray <= wgray_next;
        end
    end

    // ========================================
    // full flag
    // ========================================

    // in gray code a pointer one lap ahead differs only in the top two bits
    assign rptr_full  = {~wq2_rptr[PTR_W-1:PTR_W-2], wq2_rptr[PTR_W-3:0]};
    assign wfull_next = (wgray_next == rptr_full);

    // the synchronized read pointer lags, so full releases late but never early
    always_ff @(posedge wclk or negedge wrstn) begin
        if (!wrstn) begin
            wfull <= 1'b0;
        end else begin
            wfull <= wfull_next;
        end
    end

    // ========================================
    // memory write port
    // ========================================

    always_comb begin
        mem_wr.en   = wr_acc;
        mem_wr.addr = wbin[ADDR_W-1:0];
        mem_wr.data = wdata;
    end

endmodule

//--- sources.f
design/afifo_pkg.sv
design/afifo_mem.sv
design/afifo_wr_ctrl.sv
design/afifo_rd_ctrl.sv
design/afifo_top.sv
bench/tb_afifo.sv
